// File: control_decode.sv
// --------------------------------------------------
// Decoder stage 2
// Maps the opcode class and function bits to the
// registered datapath control bundle
// --------------------------------------------------
`timescale 1ns/1ps

module control_decode
(
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          s1_valid,
    input  logic [3:0]                    s1_class,
    input  logic [2:0]                    s1_funct3,
    input  logic                          s1_bit30,
    input  logic [decode_pkg::XLEN-1:0]   s1_imm,
    output logic                          s1_ready,

    output logic                          out_valid,
    output logic                          alu_imm_select,
    output logic                          alu_pc_select,
    output logic [3:0]                    alu_op,
    output logic                          rf_w_en,
    output logic [1:0]                    rf_w_select,
    output logic [3:0]                    store_mask,
    output logic                          branch,
    output logic                          jump,
    output logic [decode_pkg::XLEN-1:0]   imm,
    input  logic                          out_ready
);

    import decode_pkg::*;

    logic       next_imm_select;
    logic       next_pc_select;
    logic [3:0] next_alu_op;
    logic       next_rf_w_en;
    logic [1:0] next_rf_w_select;
    logic [3:0] next_store_mask;
    logic       next_branch;
    logic       next_jump;

    assign s1_ready = ~out_valid | out_ready;

    always_comb
    begin
        next_imm_select  = 1'b1;
        next_pc_select   = 1'b0;
        next_alu_op      = ALU_ADD;
        next_rf_w_en     = 1'b0;
        next_rf_w_select = WB_ALU;
        next_store_mask  = MASK_NONE;
        next_branch      = 1'b0;
        next_jump        = 1'b0;

        case (s1_class)
            CLS_R:
            begin
                next_imm_select = 1'b0;
                next_alu_op     = {s1_bit30 & ((s1_funct3 == F3_ADD_SUB) ||
                                               (s1_funct3 == F3_SRL_SRA)), s1_funct3};
                next_rf_w_en    = 1'b1;
            end
            CLS_I:
            begin
                // Bit 30 is immediate data except for SRAI
                next_alu_op  = {s1_bit30 & (s1_funct3 == F3_SRL_SRA), s1_funct3};
                next_rf_w_en = 1'b1;
            end
            CLS_LOAD:
            begin
                next_rf_w_en     = 1'b1;
                next_rf_w_select = WB_MEM;
            end
            CLS_STORE:
            begin
                case (s1_funct3)
                    F3_SB:   next_store_mask = MASK_BYTE;
                    F3_SH:   next_store_mask = MASK_HALF;
                    F3_SW:   next_store_mask = MASK_WORD;
                    default: next_store_mask = MASK_NONE;
                endcase
            end
            CLS_BRANCH:
            begin
                next_imm_select = 1'b0;
                next_pc_select  = 1'b1;
                next_alu_op     = {1'b0, s1_funct3};   // Compare code
                next_branch     = 1'b1;
            end
            CLS_JAL:
            begin
                next_pc_select   = 1'b1;
                next_rf_w_en     = 1'b1;
                next_rf_w_select = WB_PC4;
                next_jump        = 1'b1;
            end
            CLS_JALR:
            begin
                next_rf_w_en     = 1'b1;
                next_rf_w_select = WB_PC4;
                next_jump        = 1'b1;
            end
            CLS_LUI:
            begin
                next_alu_op  = ALU_PASS_B;
                next_rf_w_en = 1'b1;
            end
            CLS_AUIPC:
            begin
                next_pc_select = 1'b1;
                next_rf_w_en   = 1'b1;
            end
            default:
            begin
                next_imm_select = 1'b0;   // Unknown opcode, nothing enabled
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (s1_ready)
            out_valid <= s1_valid;
    end

    // Bundle holds while the output is stalled
    always_ff @(posedge clk)
    begin
        if (s1_valid && s1_ready)
        begin
            alu_imm_select <= next_imm_select;
            alu_pc_select  <= next_pc_select;
            alu_op         <= next_alu_op;
            rf_w_en        <= next_rf_w_en;
            rf_w_select    <= next_rf_w_select;
            store_mask     <= next_store_mask;
            branch         <= next_branch;
            jump           <= next_jump;
            imm            <= s1_imm;
        end
    end

endmodule

// File: decode_pkg.sv
// --------------------------------------------------
// RV32I decoder shared definitions
// Opcodes, opcode classes, ALU and write-back codes,
// store masks and the instruction format union
// --------------------------------------------------
package decode_pkg;

    localparam int XLEN = 32;

    // Standard RV32I major opcodes
    localparam logic [6:0] OPC_R      = 7'b0110011;
    localparam logic [6:0] OPC_I      = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // Opcode classes handed from stage 1 to stage 2
    localparam logic [3:0] CLS_R      = 4'd0;
    localparam logic [3:0] CLS_I      = 4'd1;
    localparam logic [3:0] CLS_LOAD   = 4'd2;
    localparam logic [3:0] CLS_STORE  = 4'd3;
    localparam logic [3:0] CLS_BRANCH = 4'd4;
    localparam logic [3:0] CLS_JAL    = 4'd5;
    localparam logic [3:0] CLS_JALR   = 4'd6;
    localparam logic [3:0] CLS_LUI    = 4'd7;
    localparam logic [3:0] CLS_AUIPC  = 4'd8;
    localparam logic [3:0] CLS_NONE   = 4'd15;

    // funct3 values that need special handling
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_SB      = 3'b000;
    localparam logic [2:0] F3_SH      = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;

    // ALU operation is {bit30 qualifier, funct3}
    localparam logic [3:0] ALU_ADD    = 4'b0000;
    localparam logic [3:0] ALU_PASS_B = 4'b1111;   // LUI passes the immediate

    localparam logic [1:0] WB_ALU = 2'd0;
    localparam logic [1:0] WB_MEM = 2'd1;
    localparam logic [1:0] WB_PC4 = 2'd2;

    localparam logic [3:0] MASK_NONE = 4'b0000;
    localparam logic [3:0] MASK_BYTE = 4'b0001;
    localparam logic [3:0] MASK_HALF = 4'b0011;
    localparam logic [3:0] MASK_WORD = 4'b1111;

    // One instruction word, six format views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

endpackage

// File: decoder_checker.sv
// --------------------------------------------------
// Decoder interface checker
// Reset, stall and ready assertions bound to the top
// --------------------------------------------------
`timescale 1ns/1ps

module decoder_checker
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic                          in_ready,
    input  logic                          out_valid,
    input  logic                          out_ready,
    input  logic                          alu_imm_select,
    input  logic                          alu_pc_select,
    input  logic [3:0]                    alu_op,
    input  logic                          rf_w_en,
    input  logic [1:0]                    rf_w_select,
    input  logic [3:0]                    store_mask,
    input  logic                          branch,
    input  logic                          jump,
    input  logic [decode_pkg::XLEN-1:0]   imm
);

    logic [1:0] in_flight;   // Items held in the two stages

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            in_flight <= 2'd0;
        else
            in_flight <= in_flight + {1'b0, in_valid && in_ready}
                                   - {1'b0, out_valid && out_ready};
    end

    reset_clears_output: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid is high in the cycle after reset");

    // Stalled item must not change or vanish
    stall_holds_output: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid &&
        $stable({alu_imm_select, alu_pc_select, alu_op, rf_w_en, rf_w_select,
                 store_mask, branch, jump, imm}))
        else $error("Output bundle changed while stalled");

    // Input stalls only with both stages full and the output blocked
    ready_tracks_fill: assert property (@(posedge clk) disable iff (!rst_n)
        in_ready == (out_ready || (in_flight < 2'd2)))
        else $error("in_ready does not match the number of items in the pipeline");

endmodule

// File: decoder_top.sv
// --------------------------------------------------
// Pipelined RV32I instruction decoder
// Field stage followed by the control stage
// --------------------------------------------------
`timescale 1ns/1ps

module decoder_top
(
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          in_valid,
    input  logic [decode_pkg::XLEN-1:0]   in_instr,
    output logic                          in_ready,

    output logic                          out_valid,
    output logic                          alu_imm_select,
    output logic                          alu_pc_select,
    output logic [3:0]                    alu_op,
    output logic                          rf_w_en,
    output logic [1:0]                    rf_w_select,
    output logic [3:0]                    store_mask,
    output logic                          branch,
    output logic                          jump,
    output logic [decode_pkg::XLEN-1:0]   imm,
    input  logic                          out_ready
);

    import decode_pkg::*;

    logic            s1_valid;
    logic            s1_ready;
    logic [3:0]      s1_class;
    logic [2:0]      s1_funct3;
    logic            s1_bit30;
    logic [XLEN-1:0] s1_imm;

    field_decode u_field_decode
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_ready  (in_ready),
        .s1_valid  (s1_valid),
        .s1_class  (s1_class),
        .s1_funct3 (s1_funct3),
        .s1_bit30  (s1_bit30),
        .s1_imm    (s1_imm),
        .s1_ready  (s1_ready)
    );

    control_decode u_control_decode
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .s1_valid       (s1_valid),
        .s1_class       (s1_class),
        .s1_funct3      (s1_funct3),
        .s1_bit30       (s1_bit30),
        .s1_imm         (s1_imm),
        .s1_ready       (s1_ready),
        .out_valid      (out_valid),
        .alu_imm_select (alu_imm_select),
        .alu_pc_select  (alu_pc_select),
        .alu_op         (alu_op),
        .rf_w_en        (rf_w_en),
        .rf_w_select    (rf_w_select),
        .store_mask     (store_mask),
        .branch         (branch),
        .jump           (jump),
        .imm            (imm),
        .out_ready      (out_ready)
    );

endmodule

// File: field_decode.sv
// --------------------------------------------------
// Decoder stage 1
// Accepts an instruction, classifies its opcode and
// registers funct3, bit 30 and the extended immediate
// --------------------------------------------------
`timescale 1ns/1ps

module field_decode
(
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          in_valid,
    input  decode_pkg::instr_u            in_instr,
    output logic                          in_ready,

    output logic                          s1_valid,
    output logic [3:0]                    s1_class,
    output logic [2:0]                    s1_funct3,
    output logic                          s1_bit30,
    output logic [decode_pkg::XLEN-1:0]   s1_imm,
    input  logic                          s1_ready
);

    import decode_pkg::*;

    logic [3:0]      instr_class;
    logic [XLEN-1:0] instr_imm;

    // Empty stage or draining stage can take a new word
    assign in_ready = ~s1_valid | s1_ready;

    always_comb
    begin
        case (in_instr.r.opcode)
            OPC_R:      instr_class = CLS_R;
            OPC_I:      instr_class = CLS_I;
            OPC_LOAD:   instr_class = CLS_LOAD;
            OPC_STORE:  instr_class = CLS_STORE;
            OPC_BRANCH: instr_class = CLS_BRANCH;
            OPC_JAL:    instr_class = CLS_JAL;
            OPC_JALR:   instr_class = CLS_JALR;
            OPC_LUI:    instr_class = CLS_LUI;
            OPC_AUIPC:  instr_class = CLS_AUIPC;
            default:    instr_class = CLS_NONE;   // FENCE, SYSTEM and the rest
        endcase
    end

    always_comb
    begin
        case (instr_class)
            CLS_I, CLS_LOAD, CLS_JALR:
            begin
                instr_imm = {{20{in_instr.i.imm[11]}}, in_instr.i.imm};
            end
            CLS_STORE:
            begin
                instr_imm = {{20{in_instr.s.imm_hi[6]}},
                             in_instr.s.imm_hi,
                             in_instr.s.imm_lo};
            end
            CLS_BRANCH:
            begin
                instr_imm = {{19{in_instr.b.imm_12}},
                             in_instr.b.imm_12,
                             in_instr.b.imm_11,
                             in_instr.b.imm_10_5,
                             in_instr.b.imm_4_1,
                             1'b0};
            end
            CLS_LUI, CLS_AUIPC:
            begin
                instr_imm = {in_instr.u.imm, 12'b0};
            end
            CLS_JAL:
            begin
                instr_imm = {{11{in_instr.j.imm_20}},
                             in_instr.j.imm_20,
                             in_instr.j.imm_19_12,
                             in_instr.j.imm_11,
                             in_instr.j.imm_10_1,
                             1'b0};
            end
            default:
            begin
                instr_imm = '0;   // R-type has no immediate
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else if (in_ready)
            s1_valid <= in_valid;
    end

    // Payload loads on the input handshake only
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            s1_class  <= instr_class;
            s1_funct3 <= in_instr.r.funct3;
            s1_bit30  <= in_instr.r.funct7[5];
            s1_imm    <= instr_imm;
        end
    end

endmodule

// File: tb.f
decode_pkg.sv
field_decode.sv
control_decode.sv
decoder_top.sv
decoder_checker.sv
tb_decoder.sv

// File: tb_decoder.sv
// --------------------------------------------------
// Decoder testbench
// Table driven stimulus with random output stalls
// --------------------------------------------------
`timescale 1ns/1ps

module tb_decoder;

    import decode_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          RESET_CYCLES = 5;
    localparam int          NUM_ENTRIES  = 29;
    localparam logic [31:0] LCG_SEED     = 32'h5f904e7e;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    instr_u          in_instr;
    logic            in_ready;
    logic            out_valid;
    logic            alu_imm_select;
    logic            alu_pc_select;
    logic [3:0]      alu_op;
    logic            rf_w_en;
    logic [1:0]      rf_w_select;
    logic [3:0]      store_mask;
    logic            branch;
    logic            jump;
    logic [XLEN-1:0] imm;
    logic            out_ready;

    // {imm_sel, pc_sel, alu_op, rf_w_en, wb_sel, mask, branch, jump, imm}
    logic [46:0]     exp_tab [NUM_ENTRIES];
    logic [31:0]     instr_tab [NUM_ENTRIES];
    logic [46:0]     exp_q [$];
    logic [46:0]     expected;
    int              entry_count;
    int              checked_count;
    logic [31:0]     lcg_state;

    decoder_top u_decoder_top
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_instr       (in_instr),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .alu_imm_select (alu_imm_select),
        .alu_pc_select  (alu_pc_select),
        .alu_op         (alu_op),
        .rf_w_en        (rf_w_en),
        .rf_w_select    (rf_w_select),
        .store_mask     (store_mask),
        .branch         (branch),
        .jump           (jump),
        .imm            (imm),
        .out_ready      (out_ready)
    );

    bind decoder_top decoder_checker u_decoder_checker
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .alu_imm_select (alu_imm_select),
        .alu_pc_select  (alu_pc_select),
        .alu_op         (alu_op),
        .rf_w_en        (rf_w_en),
        .rf_w_select    (rf_w_select),
        .store_mask     (store_mask),
        .branch         (branch),
        .jump           (jump),
        .imm            (imm)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (exp_val !== act_val)
            abort_run($sformatf("[ERROR] %0t ns: %s expected %h, actual %h",
                                $time, name, exp_val, act_val));
    endtask

    task automatic add_entry(input logic [31:0] word, input logic [1:0] sel,
                             input logic [3:0] op, input logic wen, input logic [1:0] wb,
                             input logic [3:0] mask, input logic [1:0] flags,
                             input logic [31:0] imm_val);
        instr_tab[entry_count] = word;
        exp_tab[entry_count]   = {sel, op, wen, wb, mask, flags, imm_val};
        entry_count++;
    endtask

    // sel is {imm_sel, pc_sel}, flags is {branch, jump}
    task automatic load_table();
        add_entry(32'h002081b3, 2'b00, 4'h0, 1'b1, 2'd0, 4'h0, 2'b00, 32'h00000000); // add
        add_entry(32'h402081b3, 2'b00, 4'h8, 1'b1, 2'd0, 4'h0, 2'b00, 32'h00000000); // sub
        add_entry(32'h0020a1b3, 2'b00, 4'h2, 1'b1, 2'd0, 4'h0, 2'b00, 32'h00000000); // slt
        add_entry(32'h0020c1b3, 2'b00, 4'h4, 1'b1, 2'd0, 4'h0, 2'b00, 32'h00000000); // xor
        add_entry(32'h0020d1b3, 2'b00, 4'h5, 1'b1, 2'd0, 4'h0, 2'b00, 32'h00000000); // srl
        add_entry(32'h4020d1b3, 2'b00, 4'hd, 1'b1, 2'd0, 4'h0, 2'b00, 32'h00000000); // sra
        add_entry(32'hffb08293, 2'b10, 4'h0, 1'b1, 2'd0, 4'h0, 2'b00, 32'hfffffffb); // addi
        add_entry(32'h0640b293, 2'b10, 4'h3, 1'b1, 2'd0, 4'h0, 2'b00, 32'h00000064); // sltiu
        add_entry(32'h4000c293, 2'b10, 4'h4, 1'b1, 2'd0, 4'h0, 2'b00, 32'h00000400); // xori
        add_entry(32'h0030d293, 2'b10, 4'h5, 1'b1, 2'd0, 4'h0, 2'b00, 32'h00000003); // srli
        add_entry(32'h4030d293, 2'b10, 4'hd, 1'b1, 2'd0, 4'h0, 2'b00, 32'h00000403); // srai
        add_entry(32'h00812303, 2'b10, 4'h0, 1'b1, 2'd1, 4'h0, 2'b00, 32'h00000008); // lw
        add_entry(32'hfff10303, 2'b10, 4'h0, 1'b1, 2'd1, 4'h0, 2'b00, 32'hffffffff); // lb
        add_entry(32'h00710223, 2'b10, 4'h0, 1'b0, 2'd0, 4'h1, 2'b00, 32'h00000004); // sb
        add_entry(32'hfe711f23, 2'b10, 4'h0, 1'b0, 2'd0, 4'h3, 2'b00, 32'hfffffffe); // sh
        add_entry(32'h7e712823, 2'b10, 4'h0, 1'b0, 2'd0, 4'hf, 2'b00, 32'h000007f0); // sw
        add_entry(32'h00208863, 2'b01, 4'h0, 1'b0, 2'd0, 4'h0, 2'b10, 32'h00000010); // beq
        add_entry(32'hfe209ce3, 2'b01, 4'h1, 1'b0, 2'd0, 4'h0, 2'b10, 32'hfffffff8); // bne
        add_entry(32'h0020c0e3, 2'b01, 4'h4, 1'b0, 2'd0, 4'h0, 2'b10, 32'h00000800); // blt
        add_entry(32'h0220d063, 2'b01, 4'h5, 1'b0, 2'd0, 4'h0, 2'b10, 32'h00000020); // bge
        add_entry(32'h8020e063, 2'b01, 4'h6, 1'b0, 2'd0, 4'h0, 2'b10, 32'hfffff000); // bltu
        add_entry(32'h0020f263, 2'b01, 4'h7, 1'b0, 2'd0, 4'h0, 2'b10, 32'h00000004); // bgeu
        add_entry(32'h001000ef, 2'b11, 4'h0, 1'b1, 2'd2, 4'h0, 2'b01, 32'h00000800); // jal
        add_entry(32'hffdff06f, 2'b11, 4'h0, 1'b1, 2'd2, 4'h0, 2'b01, 32'hfffffffc); // jal
        add_entry(32'h00c280e7, 2'b10, 4'h0, 1'b1, 2'd2, 4'h0, 2'b01, 32'h0000000c); // jalr
        add_entry(32'h12345537, 2'b10, 4'hf, 1'b1, 2'd0, 4'h0, 2'b00, 32'h12345000); // lui
        add_entry(32'hfffff517, 2'b11, 4'h0, 1'b1, 2'd0, 4'h0, 2'b00, 32'hfffff000); // auipc
        add_entry(32'h0ff0000f, 2'b00, 4'h0, 1'b0, 2'd0, 4'h0, 2'b00, 32'h00000000); // fence
        add_entry(32'h00000073, 2'b00, 4'h0, 1'b0, 2'd0, 4'h0, 2'b00, 32'h00000000); // ecall
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #((RESET_CYCLES + NUM_ENTRIES * 20) * CLK_PERIOD);
        abort_run("Timeout: the decoder did not return every instruction in time");
    end

    // Random stalls on the output side
    initial
    begin
        forever
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (rst_n)
            begin
                lcg_state = lcg_next(lcg_state);
                out_ready = (lcg_state[31:30] != 2'b00);
            end
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk)
    begin
        if (rst_n && out_valid && out_ready)
        begin
            if (exp_q.size() == 0)
                abort_run("Decoder produced an output with no instruction pending");
            expected = exp_q.pop_front();
            check_value("alu_imm_select", expected[46], alu_imm_select);
            check_value("alu_pc_select", expected[45], alu_pc_select);
            check_value("alu_op", expected[44:41], alu_op);
            check_value("rf_w_en", expected[40], rf_w_en);
            check_value("rf_w_select", expected[39:38], rf_w_select);
            check_value("store_mask", expected[37:34], store_mask);
            check_value("branch", expected[33], branch);
            check_value("jump", expected[32], jump);
            check_value("imm", expected[31:0], imm);
            checked_count++;
        end
    end

    initial
    begin
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_instr      = '0;
        out_ready     = 1'b0;
        lcg_state     = LCG_SEED;
        entry_count   = 0;
        checked_count = 0;
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        for (int n = 0; n < NUM_ENTRIES; n++)
        begin
            in_valid = 1'b1;
            in_instr = instr_tab[n];
            @(negedge clk);
            while (!in_ready)
                @(negedge clk);
            exp_q.push_back(exp_tab[n]);   // Transfers on the next edge
            @(posedge clk);
            #DRIVE_DELAY;
        end
        in_valid = 1'b0;

        wait (checked_count == NUM_ENTRIES);
        repeat (4)
        begin
            @(negedge clk);
            if (out_valid)
                abort_run("Decoder produced more outputs than instructions sent");
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule
